//--- sources.f
src/mac_ctrl_pkg.sv
src/mac_types_pkg.sv
src/mac_fastadd.sv
src/mac_add.sv
src/mac_issue.sv
src/mac_retire.sv
src/mac_unit.sv
sim/mac_unit_properties.sv
sim/mac_unit_tb.sv

//--- sim/mac_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_tb;

  import mac_ctrl_pkg::*;
  import mac_types_pkg::*;

  localparam int          n_req          = 2000;
  localparam int          burst_len      = 100;        // Back-to-back, no stalls
  localparam int          timeout_cycles = 4 * n_req;  // Gaps and stalls stay well under 4x
  localparam int          drive_delay    = 5;
  localparam logic [31:0] lfsr_seed      = 32'h80e8_6bf7;
  localparam logic [31:0] lfsr_taps      = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  mac_req_t    in_req;
  logic        out_valid;
  logic        out_ready;
  mac_res_t    out_res;
  logic [31:0] lfsr = lfsr_seed;
  mac_word_t   exp_q[$];   // Expected addresses in request order
  int          sent;
  int          received;
  int          cycles;
  logic        took;

  mac_unit mac_unit_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  always #50 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ lfsr_taps;
      val  = {val[30:0], b};
    end
    return val;
  endfunction

  function automatic mac_req_t make_req();
    mac_req_t   req;
    logic [2:0] pick;
    req.opcode  = mac_op_t'(3'(rand_bits(3)));
    req.regs.br = 16'(rand_bits(16));
    req.regs.rb = 16'(rand_bits(16));
    req.regs.xr = 16'(rand_bits(16));
    req.regs.lca = 16'(rand_bits(16));
    req.cd      = 16'(rand_bits(16));  // Upper byte stays random in byte mode
    pick        = 3'(rand_bits(3));
    case (pick)
      3'd0: req.cd[7:0] = 8'h80;  // Most negative byte
      3'd1: req.cd[7:0] = 8'hff;
      3'd2: begin
        req.regs = {4{16'hfff0}};
        req.cd   = 16'h0020;      // Wraps past the top
      end
      default: ;
    endcase
    return req;
  endfunction

  // Selected base plus displacement, modulo 2^16
  function automatic mac_word_t expected_addr(input mac_req_t req);
    mac_word_t base;
    mac_word_t disp;
    case (req.opcode)
      op_br_d8, op_br_d16:   base = req.regs.br;
      op_rb_d8, op_rb_d16:   base = req.regs.rb;
      op_xr_d8, op_xr_d16:   base = req.regs.xr;
      op_lca_d8, op_lca_d16: base = req.regs.lca;
      default:               base = 'x;
    endcase
    case (req.opcode)
      op_br_d16, op_rb_d16, op_xr_d16, op_lca_d16: disp = req.cd;
      default: disp = {{8{req.cd[7]}}, req.cd[7:0]};
    endcase
    return base + disp;
  endfunction

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Handshakes sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Result at %0t with no request outstanding", $time);
        stop_on_failure();
      end else begin
        check_addr: assert (out_res.addr == exp_q[0]) else begin
          $display("Mismatch at %0t: out_res.addr got %h expected %h",
                   $time, out_res.addr, exp_q[0]);
          stop_on_failure();
        end
        void'(exp_q.pop_front());
        received++;
      end
    end
    if (rst_n && in_valid && in_ready) begin
      exp_q.push_back(expected_addr(in_req));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, received, n_req);
      stop_on_failure();
    end else if (mac_unit_inst.props_inst.fail_count != 0) begin
      $display("Bound assertion failed at %0t", $time);
      stop_on_failure();
    end
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    sent      = 0;
    received  = 0;
    cycles    = 0;
    took      = 1'b0;
    repeat (8) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    while (sent < n_req) begin
      @(negedge clk);
      took = in_valid && in_ready;
      @(posedge clk);
      #drive_delay;
      if (took) begin
        in_valid = 1'b0;
        sent++;
      end
      if (!in_valid && sent < n_req) begin
        if (sent < burst_len || rand_bits(2) != 2'd0) begin
          in_valid = 1'b1;
          in_req   = make_req();
        end
      end
      if (sent < burst_len) begin
        out_ready = 1'b1;
      end else begin
        out_ready = (rand_bits(3) != 3'd0);  // Stall one cycle in eight
      end
    end
    in_valid  = 1'b0;
    out_ready = 1'b1;
    wait (received == n_req);
    repeat (4) @(negedge clk);  // Catch any duplicate result
    if (exp_q.size() == 0 && received == n_req
        && mac_unit_inst.props_inst.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Run ended with %0d results and %0d still expected", received, exp_q.size());
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- sim/mac_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_valid,
  input logic                    in_ready,
  input logic                    out_valid,
  input logic                    out_ready,
  input mac_types_pkg::mac_res_t out_res
);

  int unsigned fail_count = 0;  // Read by the testbench

  // Both handshakes idle while reset is held
  idle_in_reset: assert property (@(posedge clk)
    !rst_n && $past(!rst_n) |-> !out_valid && !in_ready)
    else begin
      $error("Handshake active during reset");
      fail_count++;
    end

  // Input stays closed the first cycle after release
  idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !in_ready && !out_valid)
    else begin
      $error("Handshake active in first cycle after reset");
      fail_count++;
    end

  // Two edges from acceptance to result
  result_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready ##1 out_ready |=> out_valid)
    else begin
      $error("Result not valid two edges after acceptance");
      fail_count++;
    end

  output_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_res))
    else begin
      $error("Result dropped or changed while stalled");
      fail_count++;
    end

  // No stall downstream means a request every cycle
  full_rate: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && out_ready |-> in_ready)
    else begin
      $error("Input not ready with output unstalled");
      fail_count++;
    end

endmodule

bind mac_unit mac_unit_properties props_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_res   (out_res)
);

`default_nettype wire

//--- src/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  mac_types_pkg::mac_req_t in_req,
  output logic                    out_valid,
  input  logic                    out_ready,
  output mac_types_pkg::mac_res_t out_res
);

  import mac_ctrl_pkg::*;
  import mac_types_pkg::*;

  logic      s1_valid;
  logic      s1_ready;
  mac_ctl_t  s1_ctl;
  mac_regs_t s1_regs;
  mac_word_t s1_cd;
  mac_word_t sum;

  // Stage 1, decode and operand register
  mac_issue mac_issue_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_req   (in_req),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_ctl   (s1_ctl),
    .s1_regs  (s1_regs),
    .s1_cd    (s1_cd)
  );

  mac_add mac_add_inst (
    .ctl  (s1_ctl),
    .regs (s1_regs),
    .cd   (s1_cd),
    .sum  (sum)
  );

  // Stage 2, result register
  mac_retire mac_retire_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .s1_valid  (s1_valid),
    .s1_ready  (s1_ready),
    .sum       (sum),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

endmodule

`default_nettype wire

//--- src/mac_retire.sv
`timescale 1ns/1ps
`default_nettype none

module mac_retire (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s1_valid,
  output logic                     s1_ready,
  input  mac_types_pkg::mac_word_t sum,
  output logic                     out_valid,
  input  logic                     out_ready,
  output mac_types_pkg::mac_res_t  out_res
);

  logic load;

  // Room when empty or when current result leaves this cycle
  assign s1_ready = !out_valid || out_ready;
  assign load     = s1_valid && s1_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (s1_ready) begin
      out_valid <= s1_valid;  // Drops when taken with nothing behind it
    end
  end

  // Address held while out_ready is low
  always_ff @(posedge clk) begin
    if (load) begin
      out_res.addr <= sum;
    end
  end

endmodule

`default_nettype wire

//--- src/mac_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mac_issue (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  mac_types_pkg::mac_req_t  in_req,
  output logic                     s1_valid,
  input  logic                     s1_ready,
  output mac_ctrl_pkg::mac_ctl_t   s1_ctl,
  output mac_types_pkg::mac_regs_t s1_regs,
  output mac_types_pkg::mac_word_t s1_cd
);

  import mac_ctrl_pkg::*;

  logic     issue_en;
  logic     accept;
  logic     cds;
  mac_src_t src;
  mac_ctl_t ctl_d;

  // Stage 1 frees up when empty or draining into retire
  assign in_ready = issue_en && (!s1_valid || s1_ready);
  assign accept   = in_valid && in_ready;

  // Base register select
  always_comb begin
    case (in_req.opcode)
      op_br_d8, op_br_d16:   src = src_br;
      op_rb_d8, op_rb_d16:   src = src_rb;
      op_xr_d8, op_xr_d16:   src = src_xr;
      op_lca_d8, op_lca_d16: src = src_lca;
      default:               src = src_br;
    endcase
  end

  // Displacement size
  always_comb begin
    case (in_req.opcode)
      op_br_d8, op_rb_d8, op_xr_d8, op_lca_d8: cds = 1'b1;
      default:                                 cds = 1'b0;
    endcase
  end

  always_comb begin
    ctl_d     = '0;
    ctl_d.cds = cds;
    case (src)
      src_br:  ctl_d.pb   = 1'b1;
      src_rb:  ctl_d.prb  = 1'b1;
      src_xr:  ctl_d.px   = 1'b1;
      src_lca: ctl_d.plca = 1'b1;
      default: ctl_d.pb   = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_en <= 1'b0;
      s1_valid <= 1'b0;
    end else begin
      issue_en <= 1'b1;  // Opens input one cycle after reset
      if (in_ready) begin
        s1_valid <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_ctl  <= ctl_d;
      s1_regs <= in_req.regs;
      s1_cd   <= in_req.cd;
    end
  end

endmodule

`default_nettype wire

//--- src/mac_add.sv
`timescale 1ns/1ps
`default_nettype none

module mac_add (
  input  mac_ctrl_pkg::mac_ctl_t   ctl,
  input  mac_types_pkg::mac_regs_t regs,
  input  mac_types_pkg::mac_word_t cd,
  output mac_types_pkg::mac_word_t sum
);

  import mac_types_pkg::*;

  mac_word_t  prp;     // Partial result bus
  logic [7:0] cde_hi;  // Extended upper displacement byte

  // Each base gated by its strobe, then ORed onto PRP
  assign prp = ({mac_word_w{ctl.pb}}   & regs.br)
             | ({mac_word_w{ctl.prb}}  & regs.rb)
             | ({mac_word_w{ctl.px}}   & regs.xr)
             | ({mac_word_w{ctl.plca}} & regs.lca);

  // Byte mode replaces CD 15..8 with copies of CD 7
  assign cde_hi = ctl.cds ? {8{cd[7]}} : cd[15:8];

  mac_fastadd mac_fastadd_inst (
    .prp    (prp),
    .cde_hi (cde_hi),
    .cd_lo  (cd[7:0]),
    .sum    (sum)
  );

endmodule

`default_nettype wire

//--- src/mac_fastadd.sv
`timescale 1ns/1ps
`default_nettype none

module mac_fastadd (
  input  mac_types_pkg::mac_word_t prp,
  input  logic [7:0]               cde_hi,
  input  logic [7:0]               cd_lo,
  output mac_types_pkg::mac_word_t sum
);

  import mac_types_pkg::*;

  mac_word_t  disp;
  mac_word_t  g;      // Bit generate
  mac_word_t  p;      // Bit propagate
  mac_word_t  c;      // Carry into each bit
  logic [3:0] grp_g;
  logic [3:0] grp_p;
  logic [3:0] grp_c;  // Carry into each group

  assign disp = {cde_hi, cd_lo};
  assign g    = prp & disp;
  assign p    = prp ^ disp;

  genvar gi;
  generate
    for (gi = 0; gi < 4; gi++) begin : gen_grp
      // Group generate and propagate
      assign grp_g[gi] = g[4*gi+3]
                       | (p[4*gi+3] & g[4*gi+2])
                       | (p[4*gi+3] & p[4*gi+2] & g[4*gi+1])
                       | (p[4*gi+3] & p[4*gi+2] & p[4*gi+1] & g[4*gi]);
      assign grp_p[gi] = &p[4*gi+3:4*gi];

      // Lookahead inside the group
      assign c[4*gi]   = grp_c[gi];
      assign c[4*gi+1] = g[4*gi] | (p[4*gi] & grp_c[gi]);
      assign c[4*gi+2] = g[4*gi+1]
                       | (p[4*gi+1] & g[4*gi])
                       | (p[4*gi+1] & p[4*gi] & grp_c[gi]);
      assign c[4*gi+3] = g[4*gi+2]
                       | (p[4*gi+2] & g[4*gi+1])
                       | (p[4*gi+2] & p[4*gi+1] & g[4*gi])
                       | (p[4*gi+2] & p[4*gi+1] & p[4*gi] & grp_c[gi]);
    end
  endgenerate

  // Second level lookahead across groups, no carry in
  assign grp_c[0] = 1'b0;
  assign grp_c[1] = grp_g[0];
  assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]);
  assign grp_c[3] = grp_g[2]
                  | (grp_p[2] & grp_g[1])
                  | (grp_p[2] & grp_p[1] & grp_g[0]);

  // Carry out of bit 15 dropped, result wraps
  assign sum = p ^ c;

endmodule

`default_nettype wire

//--- src/mac_types_pkg.sv
`default_nettype none

package mac_types_pkg;

  import mac_ctrl_pkg::*;

  localparam int mac_word_w = 16;

  typedef logic [mac_word_w-1:0] mac_word_t;

  // Candidate base registers
  typedef struct packed {
    mac_word_t br;   // ALU B register
    mac_word_t rb;   // Microcode B register
    mac_word_t xr;   // ALU X register
    mac_word_t lca;  // Load control address
  } mac_regs_t;

  // One address request, 83 bits
  typedef struct packed {
    mac_op_t   opcode;
    mac_regs_t regs;
    mac_word_t cd;   // CPU data displacement
  } mac_req_t;

  // Result word, room left for status fields
  typedef struct packed {
    mac_word_t addr;
  } mac_res_t;

endpackage

`default_nettype wire

//--- src/mac_ctrl_pkg.sv
`default_nettype none

package mac_ctrl_pkg;

  localparam int mac_op_w  = 3;
  localparam int mac_src_w = 2;

  // Microcode address opcodes, low bit set means full word displacement
  typedef enum logic [mac_op_w-1:0] {
    op_br_d8   = 3'd0,
    op_br_d16  = 3'd1,
    op_rb_d8   = 3'd2,
    op_rb_d16  = 3'd3,
    op_xr_d8   = 3'd4,
    op_xr_d16  = 3'd5,
    op_lca_d8  = 3'd6,
    op_lca_d16 = 3'd7
  } mac_op_t;

  // Base register feeding PRP
  typedef enum logic [mac_src_w-1:0] {
    src_br  = 2'd0,  // ALU B register
    src_rb  = 2'd1,  // Microcode B register
    src_xr  = 2'd2,  // ALU X register
    src_lca = 2'd3   // Load control address
  } mac_src_t;

  // Decoded strobes, one hot on pb..plca
  typedef struct packed {
    logic pb;
    logic prb;
    logic px;
    logic plca;
    logic cds;   // Byte displacement
  } mac_ctl_t;

endpackage

`default_nettype wire
